/* tag_mem_pkg.sv */
// shared widths, command bit positions and encodings, imported by every tag memory block
`default_nettype none

package tag_mem_pkg;

    localparam int ADDR_W    = 6;
    localparam int NUM_BANKS = 3;
    localparam int CMD_W     = 14;

    typedef logic [15:0]       word_t;
    typedef logic [ADDR_W-1:0] addr_t;

    typedef enum logic [1:0] {
        BANK_EPC = 2'd0,
        BANK_S1  = 2'd1,
        BANK_S2  = 2'd2
    } bank_e;

    // rx_cmd bit positions
    localparam int CMD_SELECT       = 4;
    localparam int CMD_EPC_READ     = 7;
    localparam int CMD_EPC_WRITE    = 8;
    localparam int CMD_SENSOR_WRITE = 10;
    localparam int CMD_SENSOR_READ  = 11;

    localparam logic [1:0] MEMBANK_EPC    = 2'd1;
    localparam logic [2:0] SEL_TARGET_SL  = 3'd4; // lower targets hit the inventoried flag
    localparam addr_t      CODE_WORD_ADDR = 6'd2;
    localparam addr_t      BANK_MAX       = 6'd63;

    typedef enum logic [3:0] {
        S_IDLE    = 4'b0001,
        S_PHASE1  = 4'b0010,
        S_PHASE2  = 4'b0100,
        S_RELEASE = 4'b1000
    } seq_state_e;

endpackage

`default_nettype wire

/* word_access_if.sv */
// access request channel from the command decoder to the access sequencer
`timescale 1ns/1ps
`default_nettype none

interface word_access_if import tag_mem_pkg::*; ();

    logic  start; // one-cycle request strobe
    logic  write;
    bank_e bank;
    word_t wdata;
    logic  busy;

    modport decoder (
        output start, write, bank, wdata,
        input  busy
    );

    modport sequencer (
        input  start, write, bank, wdata,
        output busy
    );

endinterface

`default_nettype wire

/* tx_word_if.sv */
// word fetch handshake between the access sequencer and the tx serializer
`timescale 1ns/1ps
`default_nettype none

interface tx_word_if import tag_mem_pkg::*; ();

    word_t word;
    logic  word_valid; // pulse, one cycle
    logic  last;       // word came from address 0
    logic  next_word;

    modport sequencer (
        output word, word_valid, last,
        input  next_word
    );

    modport serializer (
        input  word, word_valid, last,
        output next_word
    );

endinterface

`default_nettype wire

/* bank_counter.sv */
// write counter of one memory bank, saturating, one instance per bank
`timescale 1ns/1ps
`default_nettype none

module bank_counter import tag_mem_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  inc,
    output addr_t count
);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (inc && (count != BANK_MAX)) begin // full bank keeps its count
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* command_decoder.sv */
// command decoder: select flags, code word tracking and access requests to the sequencer
`timescale 1ns/1ps
`default_nettype none

module command_decoder import tag_mem_pkg::*; (
    input  logic             clk,
    input  logic             reset,
    input  logic             packet_complete,
    input  logic [CMD_W-1:0] rx_cmd,
    input  logic [2:0]       sel_target,
    input  logic [2:0]       sel_action,
    input  word_t            mask,
    input  logic [1:0]       mem_bank,
    input  logic [2:0]       sensor_code,
    input  word_t            epc_data_in,
    input  logic             epc_data_ready,
    input  logic [7:0]       adc_data,
    input  logic             adc_data_ready,
    input  logic [7:0]       time_stamp,
    input  logic             tx_enable,
    output logic             inven_flag,
    output logic             sl_flag,
    word_access_if.decoder   acc
);

    logic  epc_rdy_q;
    logic  adc_rdy_q;
    logic  sensor_ok;
    logic  can_issue;
    logic  epc_wr;
    logic  sensor_wr;
    logic  epc_rd;
    logic  sensor_rd;
    logic  sel_hit;
    logic  mask_match;
    bank_e sensor_bank;
    word_t code_word;
    addr_t epc_wr_idx; // shadow of the epc bank count

    // new flag value for a select, per action code
    function automatic logic sel_apply(input logic cur, input logic match,
                                       input logic [2:0] action);
        logic nxt;
        nxt = cur;
        if (match) begin
            case (action)
                3'd0, 3'd1: nxt = 1'b1;
                3'd3:       nxt = ~cur;
                3'd4, 3'd5: nxt = 1'b0;
                default:    nxt = cur;
            endcase
        end else begin
            case (action)
                3'd0, 3'd2: nxt = 1'b0;
                3'd4, 3'd6: nxt = 1'b1;
                3'd7:       nxt = ~cur;
                default:    nxt = cur;
            endcase
        end
        return nxt;
    endfunction

    assign sensor_ok   = (sensor_code == 3'd1) || (sensor_code == 3'd2);
    assign sensor_bank = (sensor_code == 3'd2) ? BANK_S2 : BANK_S1;
    assign can_issue   = !acc.busy && !acc.start; // busy lags start by a cycle

    assign epc_wr    = epc_data_ready && !epc_rdy_q && rx_cmd[CMD_EPC_WRITE]
                       && (mem_bank == MEMBANK_EPC);
    assign sensor_wr = adc_data_ready && !adc_rdy_q && rx_cmd[CMD_SENSOR_WRITE] && sensor_ok;
    // reads only make sense with the transmitter enabled
    assign epc_rd    = packet_complete && tx_enable && rx_cmd[CMD_EPC_READ]
                       && (mem_bank == MEMBANK_EPC);
    assign sensor_rd = packet_complete && tx_enable && rx_cmd[CMD_SENSOR_READ] && sensor_ok;

    assign sel_hit    = packet_complete && rx_cmd[CMD_SELECT] && (mem_bank == MEMBANK_EPC);
    assign mask_match = (mask == code_word);

    always_ff @(posedge clk) begin
        if (reset) begin
            epc_rdy_q  <= 1'b0;
            adc_rdy_q  <= 1'b0;
            acc.start  <= 1'b0;
            epc_wr_idx <= '0;
            code_word  <= '0;
            inven_flag <= 1'b1;
            sl_flag    <= 1'b1;
        end else begin
            epc_rdy_q <= epc_data_ready;
            adc_rdy_q <= adc_data_ready;
            acc.start <= can_issue && (epc_wr || sensor_wr || epc_rd || sensor_rd);
            if (can_issue && epc_wr) begin
                if (epc_wr_idx == CODE_WORD_ADDR) begin
                    code_word <= epc_data_in;
                end
                if (epc_wr_idx != BANK_MAX) begin
                    epc_wr_idx <= epc_wr_idx + 1'b1;
                end
            end
            if (sel_hit) begin
                if (sel_target < SEL_TARGET_SL) begin
                    inven_flag <= sel_apply(inven_flag, mask_match, sel_action);
                end else if (sel_target == SEL_TARGET_SL) begin
                    sl_flag <= sel_apply(sl_flag, mask_match, sel_action);
                end
            end
        end
    end

    // request payload, held until the next issue
    always_ff @(posedge clk) begin
        if (can_issue) begin
            if (epc_wr) begin
                acc.write <= 1'b1;
                acc.bank  <= BANK_EPC;
                acc.wdata <= epc_data_in;
            end else if (sensor_wr) begin
                acc.write <= 1'b1;
                acc.bank  <= sensor_bank;
                acc.wdata <= {time_stamp, adc_data};
            end else if (epc_rd || sensor_rd) begin
                acc.write <= 1'b0;
                acc.bank  <= epc_rd ? BANK_EPC : sensor_bank;
            end
        end
    end

endmodule

`default_nettype wire

/* access_sequencer.sv */
// memory macro phase sequencer for word writes and word fetches of a bank read
`timescale 1ns/1ps
`default_nettype none

module access_sequencer import tag_mem_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 tx_enable,
    input  addr_t                counts [NUM_BANKS],
    input  word_t                mem_read_in,
    output logic [NUM_BANKS-1:0] inc,
    output logic                 pc_b,
    output logic                 we,
    output logic                 se,
    output logic [NUM_BANKS-1:0] mem_sel,
    output addr_t                mem_address,
    output word_t                mem_data_out,
    word_access_if.sequencer     acc,
    tx_word_if.sequencer         tx
);

    seq_state_e state;
    logic       cur_write;
    logic       rd_active; // read open until tx_enable drops
    logic       rd_empty;
    logic       accept;
    logic       fetch_go;
    addr_t      rd_addr;
    word_t      wr_data;

    assign accept   = (state == S_IDLE) && acc.start;
    assign fetch_go = rd_active && (state == S_IDLE) && tx.next_word;
    assign acc.busy = rd_active || (state != S_IDLE);
    // mem_sel already holds the bank one-hot during the write
    assign inc      = ((state == S_PHASE2) && cur_write) ? mem_sel : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= S_IDLE;
            pc_b          <= 1'b1;
            we            <= 1'b0;
            se            <= 1'b0;
            cur_write     <= 1'b0;
            rd_active     <= 1'b0;
            tx.word_valid <= 1'b0;
        end else begin
            tx.word_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept) begin
                        cur_write <= acc.write;
                        if (acc.write) begin
                            state <= S_PHASE1;
                            pc_b  <= 1'b0;
                        end else begin
                            rd_active <= 1'b1;
                        end
                    end else if (fetch_go) begin
                        state <= S_PHASE1;
                        pc_b  <= 1'b0;
                    end else if (rd_active && !tx_enable) begin
                        rd_active <= 1'b0;
                    end
                end
                S_PHASE1: begin
                    pc_b  <= 1'b1;
                    we    <= cur_write;
                    se    <= !cur_write;
                    state <= S_PHASE2;
                end
                S_PHASE2: begin
                    tx.word_valid <= !cur_write;
                    state         <= S_RELEASE;
                end
                S_RELEASE: begin
                    we    <= 1'b0;
                    se    <= 1'b0;
                    state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_data     <= acc.wdata;
            mem_address <= counts[acc.bank];
            mem_sel     <= NUM_BANKS'(1) << acc.bank;
            rd_addr     <= counts[acc.bank] - 1'b1; // newest word first
            rd_empty    <= (counts[acc.bank] == '0);
        end else if (fetch_go) begin
            mem_address <= rd_addr;
        end
        if ((state == S_PHASE1) && cur_write) begin
            mem_data_out <= wr_data;
        end
        if ((state == S_PHASE2) && !cur_write) begin
            tx.word <= rd_empty ? '0 : mem_read_in;
            tx.last <= rd_empty || (rd_addr == '0);
            rd_addr <= rd_addr - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tx_serializer.sv */
// serial bit output of fetched words, one bit per data_clk rising edge, msb first
`timescale 1ns/1ps
`default_nettype none

module tx_serializer import tag_mem_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          data_clk,
    input  logic          tx_enable,
    output logic          tx_bit,
    output logic          tx_done,
    tx_word_if.serializer tx
);

    logic [2:0] dclk_sr; // two sync stages plus previous value
    logic       dclk_rise;
    logic       started;
    logic       cur_last;
    logic       shift_en;
    logic [3:0] bit_cnt;
    word_t      shift;

    assign dclk_rise = dclk_sr[1] && !dclk_sr[2];
    assign shift_en  = dclk_rise && tx_enable && started && !tx_done && !tx.word_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            dclk_sr      <= '0;
            started      <= 1'b0;
            cur_last     <= 1'b0;
            bit_cnt      <= '0;
            tx_bit       <= 1'b0;
            tx_done      <= 1'b0;
            tx.next_word <= 1'b0;
        end else begin
            dclk_sr      <= {dclk_sr[1:0], data_clk};
            tx.next_word <= 1'b0;
            if (!tx_enable) begin
                started <= 1'b0;
                bit_cnt <= '0;
                tx_bit  <= 1'b0;
                tx_done <= 1'b0;
            end else if (tx.word_valid) begin
                cur_last <= tx.last;
                bit_cnt  <= '0;
            end else if (dclk_rise && !tx_done && !started) begin
                started      <= 1'b1; // first edge only fetches
                tx.next_word <= 1'b1;
            end else if (shift_en) begin
                tx_bit  <= shift[15];
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd15) begin
                    tx_done      <= cur_last;
                    tx.next_word <= !cur_last;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx.word_valid) begin
            shift <= tx.word;
        end else if (shift_en) begin
            shift <= {shift[14:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

/* tag_mem_top.sv */
// tag memory controller top level, connects decoder, sequencer, serializer and bank counters
`timescale 1ns/1ps
`default_nettype none

module tag_mem_top import tag_mem_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 packet_complete,
    input  logic [CMD_W-1:0]     rx_cmd,
    input  logic [2:0]           sel_target,
    input  logic [2:0]           sel_action,
    input  word_t                mask,
    input  logic [1:0]           mem_bank,
    input  logic [2:0]           sensor_code,
    input  word_t                epc_data_in,
    input  logic                 epc_data_ready,
    input  logic [7:0]           adc_data,
    input  logic                 adc_data_ready,
    input  logic [7:0]           time_stamp,
    input  logic                 tx_enable,
    input  logic                 data_clk,
    output logic                 pc_b,
    output logic                 we,
    output logic                 se,
    output logic [NUM_BANKS-1:0] mem_sel,
    output addr_t                mem_address,
    output word_t                mem_data_out,
    input  word_t                mem_read_in,
    output logic                 tx_bit,
    output logic                 tx_done,
    output logic                 inven_flag,
    output logic                 sl_flag,
    output addr_t                epc_count,
    output addr_t                s1_count,
    output addr_t                s2_count
);

    word_access_if acc ();
    tx_word_if     tx ();

    addr_t                counts [NUM_BANKS];
    logic [NUM_BANKS-1:0] inc;

    command_decoder u_decoder (
        .clk, .reset, .packet_complete, .rx_cmd, .sel_target, .sel_action, .mask,
        .mem_bank, .sensor_code, .epc_data_in, .epc_data_ready, .adc_data,
        .adc_data_ready, .time_stamp, .tx_enable, .inven_flag, .sl_flag,
        .acc (acc.decoder)
    );

    access_sequencer u_sequencer (
        .clk, .reset, .tx_enable, .counts, .mem_read_in, .inc, .pc_b, .we, .se,
        .mem_sel, .mem_address, .mem_data_out,
        .acc (acc.sequencer),
        .tx  (tx.sequencer)
    );

    tx_serializer u_serializer (
        .clk, .reset, .data_clk, .tx_enable, .tx_bit, .tx_done,
        .tx (tx.serializer)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        bank_counter u_counter (
            .clk,
            .reset,
            .inc   (inc[i]),
            .count (counts[i])
        );
    end

    assign epc_count = counts[BANK_EPC];
    assign s1_count  = counts[BANK_S1];
    assign s2_count  = counts[BANK_S2];

endmodule

`default_nettype wire

/* tb_tag_mem.sv */
// directed testbench for the tag memory controller, built from tb.f and run by the Makefile
`timescale 1ns/1ps
`default_nettype none

module tb_tag_mem import tag_mem_pkg::*; ();

    logic clk, reset, packet_complete, epc_data_ready, adc_data_ready, tx_enable, data_clk;
    logic [CMD_W-1:0] rx_cmd;
    logic [2:0] sel_target, sel_action, sensor_code;
    logic [1:0] mem_bank;
    logic [7:0] adc_data, time_stamp;
    word_t mask, epc_data_in, mem_read_in, mem_data_out;
    logic pc_b, we, se, tx_bit, tx_done, inven_flag, sl_flag;
    logic [NUM_BANKS-1:0] mem_sel;
    addr_t mem_address, epc_count, s1_count, s2_count;

    word_t mem_model [NUM_BANKS][64];
    word_t epc_words [$];
    word_t s1_words [$];
    word_t exp_words [$]; // expected stream, in order
    logic  rx_bits [$];
    word_t code_word;
    logic  exp_inven, exp_sl;
    int    errors, timeouts;

    tag_mem_top uut (.*);

    always #50 clk = ~clk;

    function automatic logic [1:0] sel_index(input logic [NUM_BANKS-1:0] sel);
        case (sel)
            3'b010:  return 2'd1;
            3'b100:  return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

    // memory macro model
    assign mem_read_in = se ? mem_model[sel_index(mem_sel)][mem_address] : '0;

    always @(posedge clk) begin
        if (we) begin
            mem_model[sel_index(mem_sel)][mem_address] <= mem_data_out;
        end
    end

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAIL %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout at %0t: %s never happened", $time, what);
    endtask

    function automatic addr_t count_of(input bank_e b);
        case (b)
            BANK_S1: return s1_count;
            BANK_S2: return s2_count;
            default: return epc_count;
        endcase
    endfunction

    // flag after a select; op per action, 0 keep, 1 set, 2 clear, 3 toggle
    function automatic logic select_result(input logic cur, input logic match,
                                           input logic [2:0] action);
        logic [15:0] ops;
        logic [1:0]  op;
        ops = match ? {2'd0, 2'd0, 2'd2, 2'd2, 2'd3, 2'd0, 2'd1, 2'd1}
                    : {2'd3, 2'd1, 2'd0, 2'd1, 2'd0, 2'd2, 2'd0, 2'd2};
        op = 2'(ops >> (2 * action));
        case (op)
            2'd1:    return 1'b1;
            2'd2:    return 1'b0;
            2'd3:    return ~cur;
            default: return cur;
        endcase
    endfunction

    task automatic wait_we(input logic level);
        int n;
        n = 0;
        while (we !== level && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (we !== level) begin
            report_timeout(level ? "we rising" : "we falling");
        end
    endtask

    task automatic check_write(input bank_e bank, input word_t data, input addr_t old_count);
        int n;
        wait_we(1'b1);
        check_count(mem_address, old_count, "write address");
        check_flag(mem_sel[0], bank == BANK_EPC, "mem_sel epc");
        check_flag(mem_sel[1], bank == BANK_S1, "mem_sel s1");
        check_flag(mem_sel[2], bank == BANK_S2, "mem_sel s2");
        check_word(mem_data_out, data, "write data");
        n = 0;
        while (count_of(bank) == old_count && n < 20) begin
            @(posedge clk);
            n++;
        end
        check_count(count_of(bank), old_count + 1'b1, "bank count after write");
        wait_we(1'b0);
        @(posedge clk);
    endtask

    task automatic epc_write(input word_t data);
        addr_t old;
        old = epc_count;
        rx_cmd         <= CMD_W'(1) << CMD_EPC_WRITE;
        mem_bank       <= MEMBANK_EPC;
        epc_data_in    <= data;
        epc_data_ready <= 1'b1;
        @(posedge clk);
        epc_data_ready <= 1'b0;
        check_write(BANK_EPC, data, old);
        epc_words.push_back(data);
    endtask

    task automatic sensor_write(input logic [2:0] code, input logic [7:0] ts,
                                input logic [7:0] adc);
        bank_e bank;
        addr_t old;
        bank = (code == 3'd2) ? BANK_S2 : BANK_S1;
        old = count_of(bank);
        rx_cmd         <= CMD_W'(1) << CMD_SENSOR_WRITE;
        sensor_code    <= code;
        time_stamp     <= ts;
        adc_data       <= adc;
        adc_data_ready <= 1'b1;
        @(posedge clk);
        adc_data_ready <= 1'b0;
        check_write(bank, {ts, adc}, old); // timestamp byte on top
        if (bank == BANK_S1) begin
            s1_words.push_back({ts, adc});
        end
    endtask

    task automatic do_select(input logic [2:0] target, input logic [2:0] action,
                             input word_t m, input logic [1:0] bank);
        rx_cmd          <= CMD_W'(1) << CMD_SELECT;
        sel_target      <= target;
        sel_action      <= action;
        mask            <= m;
        mem_bank        <= bank;
        packet_complete <= 1'b1;
        @(posedge clk);
        packet_complete <= 1'b0;
        @(posedge clk); // flags settle one cycle after the strobe
        check_flag(inven_flag, exp_inven, "inven_flag");
        check_flag(sl_flag, exp_sl, "sl_flag");
    endtask

    task automatic select_with_match(input logic [2:0] target, input logic [2:0] action,
                                     input logic match);
        if (target == 3'd4) begin
            exp_sl = select_result(exp_sl, match, action);
        end else begin
            exp_inven = select_result(exp_inven, match, action);
        end
        do_select(target, action, match ? code_word : ~code_word, MEMBANK_EPC);
    endtask

    // one data_clk period, outputs sampled late in the high half
    task automatic data_clk_period(output logic bit_seen, output logic done_seen);
        data_clk <= 1'b1;
        repeat (8) @(posedge clk);
        bit_seen  = tx_bit;
        done_seen = tx_done;
        data_clk <= 1'b0;
        repeat (8) @(posedge clk);
    endtask

    task automatic start_read(input logic [2:0] code);
        logic b, d;
        rx_bits.delete();
        tx_enable       <= 1'b1;
        rx_cmd          <= CMD_W'(1) << CMD_SENSOR_READ;
        sensor_code     <= code;
        packet_complete <= 1'b1;
        @(posedge clk);
        packet_complete <= 1'b0;
        repeat (4) @(posedge clk);
        data_clk_period(b, d); // first edge only fetches
    endtask

    task automatic collect_bits();
        logic b, d;
        d = 1'b0;
        while (!d && rx_bits.size() < 128) begin
            data_clk_period(b, d);
            rx_bits.push_back(b);
        end
        if (!d) begin
            report_timeout("tx_done rising");
        end
    endtask

    task automatic stop_read();
        int n;
        check_flag(tx_done, 1'b1, "tx_done after last bit");
        tx_enable <= 1'b0;
        n = 0;
        while (tx_done && n < 20) begin
            @(posedge clk);
            n++;
        end
        check_flag(tx_done, 1'b0, "tx_done after tx_enable low");
        repeat (2) @(posedge clk);
    endtask

    task automatic check_stream();
        word_t got;
        if (rx_bits.size() != 16 * exp_words.size()) begin
            errors++;
            $display("FAIL %0t: stream has %0d bits, expected %0d", $time, rx_bits.size(),
                     16 * exp_words.size());
        end
        for (int w = 0; w < exp_words.size(); w++) begin
            got = '0;
            for (int i = 0; i < 16; i++) begin
                if (16 * w + i < rx_bits.size()) begin
                    got = {got[14:0], rx_bits[16 * w + i]}; // msb first
                end
            end
            check_word(got, exp_words[w], "stream word");
        end
    endtask

    task automatic check_reset();
        check_flag(pc_b, 1'b1, "pc_b after reset");
        check_flag(we, 1'b0, "we after reset");
        check_flag(se, 1'b0, "se after reset");
        check_flag(tx_bit, 1'b0, "tx_bit after reset");
        check_flag(tx_done, 1'b0, "tx_done after reset");
        check_count(epc_count, '0, "epc_count after reset");
        check_count(s1_count, '0, "s1_count after reset");
        check_count(s2_count, '0, "s2_count after reset");
        check_flag(inven_flag, 1'b1, "inven_flag after reset");
        check_flag(sl_flag, 1'b1, "sl_flag after reset");
    endtask

    task automatic test_epc_write();
        for (int i = 0; i < 4; i++) begin
            epc_write(word_t'($urandom()));
        end
        code_word = epc_words[2];
        check_count(epc_count, 6'd4, "epc_count");
    endtask

    task automatic test_select();
        logic [2:0] target;
        for (int t = 0; t < 2; t++) begin
            target = (t == 1) ? 3'd4 : 3'd2;
            for (int k = 0; k < 32; k++) begin
                select_with_match(target, 3'd0, k[4]); // preset flag to k[4]
                select_with_match(target, k[2:0], ~k[3]);
            end
        end
        do_select(3'd5, 3'd3, code_word, MEMBANK_EPC); // target above sl
        do_select(3'd1, 3'd3, code_word, 2'd2);       // wrong bank
    endtask

    task automatic test_empty_read();
        exp_words.delete();
        exp_words.push_back(16'h0000);
        start_read(3'd2);
        // write to the same bank while the read is open
        rx_cmd         <= CMD_W'(1) << CMD_SENSOR_WRITE;
        adc_data_ready <= 1'b1;
        @(posedge clk);
        adc_data_ready <= 1'b0;
        repeat (8) @(posedge clk);
        collect_bits();
        check_stream();
        stop_read();
        check_count(s2_count, '0, "s2_count after dropped write");
    endtask

    task automatic test_sensor_write();
        for (int i = 0; i < 3; i++) begin
            sensor_write(3'd1, 8'($urandom()), 8'($urandom()));
        end
        sensor_write(3'd2, 8'($urandom()), 8'($urandom()));
        check_count(s1_count, 6'd3, "s1_count");
        check_count(s2_count, 6'd1, "s2_count");
        check_count(epc_count, 6'd4, "epc_count after sensor writes");
    endtask

    task automatic test_bank_read();
        exp_words.delete();
        for (int i = s1_words.size() - 1; i >= 0; i--) begin
            exp_words.push_back(s1_words[i]); // newest first
        end
        start_read(3'd1);
        collect_bits();
        check_stream();
        stop_read();
        check_count(s1_count, 6'd3, "s1_count after read");
    endtask

    initial begin
        void'($urandom(32'h6e0b_d75d));
        clk             = 1'b0;
        reset           = 1'b1;
        packet_complete = 1'b0;
        rx_cmd          = '0;
        sel_target      = '0;
        sel_action      = '0;
        mask            = '0;
        mem_bank        = '0;
        sensor_code     = '0;
        epc_data_in     = '0;
        epc_data_ready  = 1'b0;
        adc_data        = '0;
        adc_data_ready  = 1'b0;
        time_stamp      = '0;
        tx_enable       = 1'b0;
        data_clk        = 1'b0;
        errors          = 0;
        timeouts        = 0;
        exp_inven       = 1'b1;
        exp_sl          = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_reset();
        test_epc_write();
        test_select();
        test_empty_read();
        test_sensor_write();
        test_bank_read();
        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
tag_mem_pkg.sv
word_access_if.sv
tx_word_if.sv
bank_counter.sv
command_decoder.sv
access_sequencer.sv
tx_serializer.sv
tag_mem_top.sv
tb_tag_mem.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = tb_tag_mem
FILELIST  = tb.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, pass only on the pass message"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir
